// ==== logic/eop_config.svh ====
/* EOP shim configuration */

`ifndef EOP_CONFIG_SVH
`define EOP_CONFIG_SVH

// Tag space and the tag width (log2 of the tag space)
`define EOP_MAX_ACTIVE_REQS    16
`define EOP_TAG_BITS           4

// Metadata field, the top bit marks reads that are not tracked
`define EOP_MDATA_BITS         8
`define EOP_RESERVED_MDATA_IDX 7

// Line count (length minus one) and read data widths
`define EOP_CL_BITS            2
`define EOP_DATA_BITS          16

// Tracking memory read latency and the clear-on-reset selection
`define EOP_RAM_LATENCY        2
`define EOP_RAM_CLEAR          1'b1
`define EOP_RAM_KEEP           1'b0

// Credit counter holds up to one credit per trackable tag
`define EOP_CREDIT_BITS        5

`endif

// ==== logic/eop_pkg.sv ====
/* EOP shim types */

`default_nettype none

`include "eop_config.svh"

package eop_pkg;

    // ========================================
    // Scalar field types
    // ========================================

    typedef logic [`EOP_TAG_BITS-1:0]   tag_t;
    typedef logic [`EOP_CL_BITS-1:0]    cl_num_t;
    typedef logic [`EOP_MDATA_BITS-1:0] mdata_t;
    typedef logic [`EOP_DATA_BITS-1:0]  data_t;

    // ========================================
    // Opcodes and memory state
    // ========================================

    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_t;

    typedef enum logic {
        RSP_READ  = 1'b0,
        RSP_WRITE = 1'b1
    } rsp_kind_t;

    // The memory sweeps to zero after reset before it serves traffic
    typedef enum logic {
        RAM_CLEAR = 1'b0,
        RAM_RUN   = 1'b1
    } ram_state_t;

    // ========================================
    // Channel headers
    // ========================================

    // Request header, cl_len holds the packet length minus one
    typedef struct packed {
        logic      valid;
        req_kind_t kind;
        mdata_t    mdata;
        cl_num_t   cl_len;
    } req_hdr_t;

    // Response header
    // When format is set one response covers the whole packet and
    // cl_num holds the packet length minus one instead of a line index
    typedef struct packed {
        logic      valid;
        rsp_kind_t kind;
        mdata_t    mdata;
        data_t     data;
        logic      format;
        cl_num_t   cl_num;
        logic      eop;
    } rsp_hdr_t;

endpackage

`default_nettype wire

// ==== logic/eop_ram.sv ====
/* Two-cycle tracking memory */

`timescale 1ns/1ps
`default_nettype none

`include "eop_config.svh"

module eop_ram
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     clear_en,
    input  logic [`EOP_TAG_BITS-1:0] raddr,
    input  logic [`EOP_TAG_BITS-1:0] waddr,
    input  logic                     wen,
    input  logic [`EOP_CL_BITS-1:0]  wdata,
    output logic [`EOP_CL_BITS-1:0]  rdata,
    output logic                     rdy
);
    import eop_pkg::*;

    // Storage array, one entry per tag
    logic [`EOP_CL_BITS-1:0] mem [0:`EOP_MAX_ACTIVE_REQS-1];

    // First read stage, the array is sampled at the address edge
    logic [`EOP_CL_BITS-1:0] rd_q;

    ram_state_t              state;
    logic [`EOP_TAG_BITS-1:0] clr_ptr;
    logic                     clr_last;

    assign clr_last = (clr_ptr == (`EOP_TAG_BITS)'(`EOP_MAX_ACTIVE_REQS - 1));
    assign rdy      = (state == RAM_RUN);

    // ========================================
    // Clear sweep control
    // ========================================

    // An instance with clear enabled walks every entry once after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= clear_en ? RAM_CLEAR : RAM_RUN;
            clr_ptr <= '0;
        end
        else if (state == RAM_CLEAR)
        begin
            clr_ptr <= clr_ptr + 1'b1;
            if (clr_last)
            begin
                state <= RAM_RUN;
            end
        end
    end

    // ========================================
    // Array access
    // ========================================

    // The sweep owns the write port until it finishes
    always_ff @(posedge clk)
    begin
        if (state == RAM_CLEAR)
        begin
            mem[clr_ptr] <= '0;
        end
        else if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Read data lands on the output register two edges after the address
    // A write on the address edge is not seen by that read
    always_ff @(posedge clk)
    begin
        rd_q  <= mem[raddr];
        rdata <= rd_q;
    end

endmodule

`default_nettype wire

// ==== logic/eop_flit_tracker.sv ====
/* Per-channel packet flit tracker */

`timescale 1ns/1ps
`default_nettype none

`include "eop_config.svh"

module eop_flit_tracker
(
    input  logic             clk,
    input  logic             reset,
    output logic             rdy,

    // New request to track
    input  logic             req_en,
    input  eop_pkg::tag_t    req_tag,
    input  eop_pkg::cl_num_t req_len,

    // New response
    input  logic             rsp_en,
    input  eop_pkg::tag_t    rsp_tag,
    input  logic             rsp_packed,

    // End of packet and packet length two cycles after the response strobe
    output logic             t2_eop,
    output eop_pkg::cl_num_t t2_len
);
    import eop_pkg::*;

    logic cnt_rdy;

    // Only the count memory sweeps, so readiness follows it
    assign rdy = cnt_rdy;

    // ========================================
    // Packet length memory
    // ========================================

    // Written by requests and read by responses, so each port has one owner
    eop_ram len_ram
    (
        .clk      (clk),
        .reset    (reset),
        .clear_en (`EOP_RAM_KEEP),
        .raddr    (rsp_tag),
        .waddr    (req_tag),
        .wen      (req_en),
        .wdata    (req_len),
        .rdata    (t2_len),
        .rdy      ()
    );

    // ========================================
    // Response pipeline
    // ========================================

    // The count read takes two cycles, and the two responses ahead of
    // this one have not written their update back yet
    logic    p_en     [1:2];
    tag_t    p_tag    [1:2];
    logic    p_packed [1:2];
    cl_num_t p_inflight [1:2];

    logic    match_1;
    logic    match_2;
    cl_num_t inflight_now;

    always_comb
    begin
        match_1      = p_en[1] && (p_tag[1] == rsp_tag);
        match_2      = p_en[2] && (p_tag[2] == rsp_tag);
        inflight_now = cl_num_t'(match_1) + cl_num_t'(match_2);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            p_en[1] <= 1'b0;
            p_en[2] <= 1'b0;
        end
        else
        begin
            p_en[1] <= rsp_en;
            p_en[2] <= p_en[1];
        end

        p_tag[1]      <= rsp_tag;
        p_tag[2]      <= p_tag[1];
        p_packed[1]   <= rsp_packed;
        p_packed[2]   <= p_packed[1];
        p_inflight[1] <= inflight_now;
        p_inflight[2] <= p_inflight[1];
    end

    // ========================================
    // Received count memory
    // ========================================

    cl_num_t rcvd_cnt;
    cl_num_t rcvd_upd;
    cl_num_t num_received;

    eop_ram cnt_ram
    (
        .clk      (clk),
        .reset    (reset),
        .clear_en (`EOP_RAM_CLEAR),
        .raddr    (rsp_tag),
        .waddr    (p_tag[2]),
        .wen      (p_en[2]),
        .wdata    (rcvd_upd),
        .rdata    (rcvd_cnt),
        .rdy      (cnt_rdy)
    );

    // Count includes the updates still in flight when the read was issued
    // The last line of a packet resets the entry for the next use of the tag
    always_comb
    begin
        num_received = rcvd_cnt + p_inflight[2];
        t2_eop       = 1'b0;
        rcvd_upd     = num_received + 1'b1;

        if (p_en[2] && (p_packed[2] || (num_received == t2_len)))
        begin
            t2_eop   = 1'b1;
            rcvd_upd = '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/eop_detect_shim.sv ====
/* EOP detect response shim */

`timescale 1ns/1ps
`default_nettype none

`include "eop_config.svh"

module eop_detect_shim
(
    input  logic              clk,
    input  logic              reset,

    // Client side requests and platform side copies
    input  eop_pkg::req_hdr_t c0_req_in,
    input  eop_pkg::req_hdr_t c1_req_in,
    output eop_pkg::req_hdr_t c0_req_out,
    output eop_pkg::req_hdr_t c1_req_out,

    // Platform responses and the client side results
    input  eop_pkg::rsp_hdr_t c0_rsp_in,
    input  eop_pkg::rsp_hdr_t c1_rsp_in,
    output eop_pkg::rsp_hdr_t c0_rsp_out,
    output eop_pkg::rsp_hdr_t c1_rsp_out,

    // Request credits, one pulse per freed slot
    input  logic              c0_credit_in,
    input  logic              c1_credit_in,
    output logic              c0_credit_out,
    output logic              c1_credit_out
);
    import eop_pkg::*;

    logic    rd_rdy;
    logic    wr_rdy;
    logic    rd_eop;
    logic    wr_eop;
    cl_num_t wr_len;

    // Requests go to the platform untouched
    assign c0_req_out = c0_req_in;
    assign c1_req_out = c1_req_in;

    // ========================================
    // Read channel
    // ========================================

    rsp_hdr_t c0_pipe    [1:`EOP_RAM_LATENCY];
    logic     rd_tracked [1:`EOP_RAM_LATENCY];
    logic     rd_tracked_in;

    // Reads with the reserved bit come from elsewhere and share no tags
    assign rd_tracked_in = c0_rsp_in.valid && (c0_rsp_in.kind == RSP_READ) &&
                           !c0_rsp_in.mdata[`EOP_RESERVED_MDATA_IDX];

    eop_flit_tracker rd_tracker
    (
        .clk        (clk),
        .reset      (reset),
        .rdy        (rd_rdy),
        .req_en     (c0_req_in.valid && (c0_req_in.kind == REQ_READ) &&
                     !c0_req_in.mdata[`EOP_RESERVED_MDATA_IDX]),
        .req_tag    (c0_req_in.mdata[`EOP_TAG_BITS-1:0]),
        .req_len    (c0_req_in.cl_len),
        .rsp_en     (rd_tracked_in),
        .rsp_tag    (c0_rsp_in.mdata[`EOP_TAG_BITS-1:0]),
        .rsp_packed (1'b0),
        .t2_eop     (rd_eop),
        .t2_len     ()
    );

    // Responses wait for the tracker, then pick up eop on the output stage
    always_ff @(posedge clk)
    begin
        c0_pipe[1]    <= c0_rsp_in;
        rd_tracked[1] <= rd_tracked_in;
        for (int i = 2; i <= `EOP_RAM_LATENCY; i++)
        begin
            c0_pipe[i]    <= c0_pipe[i-1];
            rd_tracked[i] <= rd_tracked[i-1];
        end

        c0_rsp_out     <= c0_pipe[`EOP_RAM_LATENCY];
        c0_rsp_out.eop <= rd_tracked[`EOP_RAM_LATENCY] && rd_eop;

        if (reset)
        begin
            for (int i = 1; i <= `EOP_RAM_LATENCY; i++)
            begin
                c0_pipe[i].valid <= 1'b0;
            end
            c0_rsp_out.valid <= 1'b0;
        end
    end

    // ========================================
    // Write channel
    // ========================================

    rsp_hdr_t c1_pipe [1:`EOP_RAM_LATENCY];
    rsp_hdr_t c1_last;
    logic     c1_last_is_wr;

    assign c1_last       = c1_pipe[`EOP_RAM_LATENCY];
    assign c1_last_is_wr = (c1_last.kind == RSP_WRITE);

    eop_flit_tracker wr_tracker
    (
        .clk        (clk),
        .reset      (reset),
        .rdy        (wr_rdy),
        .req_en     (c1_req_in.valid && (c1_req_in.kind == REQ_WRITE)),
        .req_tag    (c1_req_in.mdata[`EOP_TAG_BITS-1:0]),
        .req_len    (c1_req_in.cl_len),
        .rsp_en     (c1_rsp_in.valid && (c1_rsp_in.kind == RSP_WRITE)),
        .rsp_tag    (c1_rsp_in.mdata[`EOP_TAG_BITS-1:0]),
        .rsp_packed (c1_rsp_in.format),
        .t2_eop     (wr_eop),
        .t2_len     (wr_len)
    );

    // Non-final beats are dropped, the final one becomes a packed response
    always_ff @(posedge clk)
    begin
        c1_pipe[1] <= c1_rsp_in;
        for (int i = 2; i <= `EOP_RAM_LATENCY; i++)
        begin
            c1_pipe[i] <= c1_pipe[i-1];
        end

        c1_rsp_out       <= c1_last;
        c1_rsp_out.valid <= c1_last.valid && (wr_eop || !c1_last_is_wr);
        if (c1_last_is_wr)
        begin
            c1_rsp_out.format <= 1'b1;
            c1_rsp_out.cl_num <= wr_len;
            c1_rsp_out.eop    <= wr_eop;
        end

        if (reset)
        begin
            for (int i = 1; i <= `EOP_RAM_LATENCY; i++)
            begin
                c1_pipe[i].valid <= 1'b0;
            end
            c1_rsp_out.valid <= 1'b0;
        end
    end

    // ========================================
    // Credit gating
    // ========================================

    logic [1:0]                 credit_in;
    logic [1:0]                 credit_out;
    logic [`EOP_CREDIT_BITS-1:0] credit_cnt [0:1];
    logic                       both_rdy;

    assign both_rdy  = rd_rdy && wr_rdy;
    assign credit_in = {c1_credit_in, c0_credit_in};

    // Every credit passes through the counter, so after the sweep a
    // credit shows up one cycle after it arrives
    always_comb
    begin
        for (int ch = 0; ch < 2; ch++)
        begin
            credit_out[ch] = both_rdy && (credit_cnt[ch] != '0);
        end
    end

    assign c0_credit_out = credit_out[0];
    assign c1_credit_out = credit_out[1];

    always_ff @(posedge clk)
    begin
        for (int ch = 0; ch < 2; ch++)
        begin
            if (reset)
            begin
                credit_cnt[ch] <= '0;
            end
            else
            begin
                credit_cnt[ch] <= credit_cnt[ch]
                                  + (`EOP_CREDIT_BITS)'(credit_in[ch])
                                  - (`EOP_CREDIT_BITS)'(credit_out[ch]);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/eop_detect_props.sv ====
/* EOP shim properties */

`timescale 1ns/1ps
`default_nettype none

`include "eop_config.svh"

module eop_detect_props
(
    input  logic              clk,
    input  logic              reset,
    input  eop_pkg::rsp_hdr_t c0_rsp_out,
    input  eop_pkg::rsp_hdr_t c1_rsp_out,
    input  logic              c0_credit_out,
    input  logic              c1_credit_out
);
    import eop_pkg::*;

    // No credit leaves while the shim is held in reset
    credit_quiet_in_reset: assert property (@(posedge clk)
        reset |=> (!c0_credit_out && !c1_credit_out))
        else $error("Credit output high right after a reset cycle");

    // A write completion seen by the client always covers the whole packet
    merged_write_is_packed: assert property (@(posedge clk) disable iff (reset)
        (c1_rsp_out.valid && (c1_rsp_out.kind == RSP_WRITE))
            |-> (c1_rsp_out.format && c1_rsp_out.eop))
        else $error("Merged write response without format or eop");

    // Untracked reads never claim the end of a packet
    reserved_read_no_eop: assert property (@(posedge clk) disable iff (reset)
        (c0_rsp_out.valid && c0_rsp_out.mdata[`EOP_RESERVED_MDATA_IDX])
            |-> !c0_rsp_out.eop)
        else $error("Read with the reserved mdata bit carries eop");

endmodule

bind eop_detect_shim eop_detect_props props_inst
(
    .clk           (clk),
    .reset         (reset),
    .c0_rsp_out    (c0_rsp_out),
    .c1_rsp_out    (c1_rsp_out),
    .c0_credit_out (c0_credit_out),
    .c1_credit_out (c1_credit_out)
);

`default_nettype wire

// ==== tests/eop_detect_tb.sv ====
/* EOP shim testbench */

`timescale 1ns/1ps
`default_nettype none

`include "eop_config.svh"

module eop_detect_tb;
    import eop_pkg::*;

    localparam string VEC_FILE     = "tests/eop_vectors.txt";
    localparam int    CLK_PERIOD   = 100;
    localparam int    DRIVE_DELAY  = 5;
    localparam int    SETTLE_DELAY = 1;
    localparam int    RESET_LEN    = 8;
    localparam int    SWEEP_LEN    = `EOP_MAX_ACTIVE_REQS;

    // One line of the vectors file holds the inputs for a cycle and the outputs seen in it
    typedef struct packed {
        logic [7:0] test;
        logic [7:0] cyc;
        req_hdr_t   req0;
        req_hdr_t   req1;
        rsp_hdr_t   rsp0;
        rsp_hdr_t   rsp1;
        logic       credit0;
        logic       credit1;
        rsp_hdr_t   exp0;
        rsp_hdr_t   exp1;
        logic       exp_credit0;
        logic       exp_credit1;
    } vec_t;

    vec_t       vecs[$];
    logic       clk;
    logic       reset;
    req_hdr_t   c0_req_in;
    req_hdr_t   c1_req_in;
    req_hdr_t   c0_req_out;
    req_hdr_t   c1_req_out;
    rsp_hdr_t   c0_rsp_in;
    rsp_hdr_t   c1_rsp_in;
    rsp_hdr_t   c0_rsp_out;
    rsp_hdr_t   c1_rsp_out;
    logic       c0_credit_in;
    logic       c1_credit_in;
    logic       c0_credit_out;
    logic       c1_credit_out;
    int         errors;
    int         test_errors;
    int         checks;
    int         tests_run;
    logic [7:0] cur_test;
    logic [7:0] cur_cyc;
    bit         loaded;

    eop_detect_shim eop_detect_shim_inst
    (
        .clk           (clk),
        .reset         (reset),
        .c0_req_in     (c0_req_in),
        .c1_req_in     (c1_req_in),
        .c0_req_out    (c0_req_out),
        .c1_req_out    (c1_req_out),
        .c0_rsp_in     (c0_rsp_in),
        .c1_rsp_in     (c1_rsp_in),
        .c0_rsp_out    (c0_rsp_out),
        .c1_rsp_out    (c1_rsp_out),
        .c0_credit_in  (c0_credit_in),
        .c1_credit_in  (c1_credit_in),
        .c0_credit_out (c0_credit_out),
        .c1_credit_out (c1_credit_out)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // ========================================
    // Vector loading
    // ========================================

    // Channel 0 carries reads and channel 1 writes, so kinds are implied
    function automatic vec_t parse_record(int unsigned f [28]);
        vec_t v;
        v              = '0;
        v.test         = f[0][7:0];
        v.cyc          = f[1][7:0];
        v.req0.valid   = f[2][0];
        v.req0.kind    = REQ_READ;
        v.req0.mdata   = f[3][7:0];
        v.req0.cl_len  = f[4][1:0];
        v.req1.valid   = f[5][0];
        v.req1.kind    = REQ_WRITE;
        v.req1.mdata   = f[6][7:0];
        v.req1.cl_len  = f[7][1:0];
        v.rsp0.valid   = f[8][0];
        v.rsp0.kind    = RSP_READ;
        v.rsp0.mdata   = f[9][7:0];
        v.rsp0.data    = f[10][15:0];
        v.rsp1.valid   = f[11][0];
        v.rsp1.kind    = RSP_WRITE;
        v.rsp1.mdata   = f[12][7:0];
        v.rsp1.format  = f[13][0];
        v.rsp1.cl_num  = f[14][1:0];
        v.credit0      = f[15][0];
        v.credit1      = f[16][0];
        v.exp0.valid   = f[17][0];
        v.exp0.kind    = RSP_READ;
        v.exp0.mdata   = f[18][7:0];
        v.exp0.data    = f[19][15:0];
        v.exp0.eop     = f[20][0];
        v.exp1.valid   = f[21][0];
        v.exp1.kind    = RSP_WRITE;
        v.exp1.mdata   = f[22][7:0];
        v.exp1.format  = f[23][0];
        v.exp1.cl_num  = f[24][1:0];
        v.exp1.eop     = f[25][0];
        v.exp_credit0  = f[26][0];
        v.exp_credit1  = f[27][0];
        return v;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        int unsigned f [28];
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open the vectors file %s", VEC_FILE);
            errors++;
            return;
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            // Blank lines and column notes carry no record
            if (n <= 1 || line.getc(0) == "#")
            begin
                continue;
            end
            // Each hex conversion skips the white space ahead of its column
            n = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                        f[19], f[20], f[21], f[22], f[23], f[24], f[25], f[26], f[27]);
            if (n == 28)
            begin
                vecs.push_back(parse_record(f));
            end
            else
            begin
                $display("Malformed line in the vectors file: %s", line);
                errors++;
            end
        end
        $fclose(fd);
    endtask

    // ========================================
    // Drive and check
    // ========================================

    task automatic drive_inputs(vec_t v);
        c0_req_in    = v.req0;
        c1_req_in    = v.req1;
        c0_rsp_in    = v.rsp0;
        c1_rsp_in    = v.rsp1;
        c0_credit_in = v.credit0;
        c1_credit_in = v.credit1;
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("Fail test %0d cycle %0d: %s got %h expected %h",
                     cur_test, cur_cyc, name, got, exp);
            test_errors++;
        end
    endtask

    // Requests reach the platform unchanged and with no delay
    task automatic check_requests(vec_t v);
        check_value("c0_req_out", c0_req_out, v.req0);
        check_value("c1_req_out", c1_req_out, v.req1);
    endtask

    // Fields behind a low valid are don't care
    task automatic check_outputs(vec_t v);
        check_value("c0_rsp_out.valid", c0_rsp_out.valid, v.exp0.valid);
        if (v.exp0.valid)
        begin
            check_value("c0_rsp_out.kind", c0_rsp_out.kind, v.exp0.kind);
            check_value("c0_rsp_out.mdata", c0_rsp_out.mdata, v.exp0.mdata);
            check_value("c0_rsp_out.data", c0_rsp_out.data, v.exp0.data);
            check_value("c0_rsp_out.eop", c0_rsp_out.eop, v.exp0.eop);
        end
        check_value("c1_rsp_out.valid", c1_rsp_out.valid, v.exp1.valid);
        if (v.exp1.valid)
        begin
            check_value("c1_rsp_out.kind", c1_rsp_out.kind, v.exp1.kind);
            check_value("c1_rsp_out.mdata", c1_rsp_out.mdata, v.exp1.mdata);
            check_value("c1_rsp_out.format", c1_rsp_out.format, v.exp1.format);
            check_value("c1_rsp_out.cl_num", c1_rsp_out.cl_num, v.exp1.cl_num);
            check_value("c1_rsp_out.eop", c1_rsp_out.eop, v.exp1.eop);
        end
        check_value("c0_credit_out", c0_credit_out, v.exp_credit0);
        check_value("c1_credit_out", c1_credit_out, v.exp_credit1);
    endtask

    // Every step of the run sits just after a rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Cycles with no record are idle and expect every output low
    task automatic run_test(int first, int last);
        vec_t idle;
        vec_t v;
        int   idx;
        idle        = '0;
        idx         = first;
        cur_test    = vecs[first].test;
        test_errors = 0;
        for (int c = 0; c <= int'(vecs[last].cyc); c++)
        begin
            cur_cyc = c[7:0];
            if (idx <= last && vecs[idx].cyc == c[7:0])
            begin
                v = vecs[idx];
                idx++;
            end
            else
            begin
                v = idle;
            end
            check_outputs(v);
            drive_inputs(v);
            // The request path is combinational and settles within the cycle
            #SETTLE_DELAY;
            check_requests(v);
            next_cycle();
        end
        drive_inputs(idle);
        if (idx <= last)
        begin
            $display("Test %0d has records out of cycle order", cur_test);
            test_errors++;
        end
        $display("Test %0d finished with %0d errors", cur_test, test_errors);
        errors += test_errors;
        tests_run++;
    endtask

    // ========================================
    // Main sequence
    // ========================================

    initial
    begin
        int first;
        int last;
        int gap;
        clk       = 1'b0;
        reset     = 1'b1;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        drive_inputs('0);
        void'($urandom(32'h7ffe_94cf));
        load_vectors();
        loaded = 1'b1;
        repeat (RESET_LEN) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        // The first test starts right away so it sees the clear sweep
        first = 0;
        while (first < vecs.size())
        begin
            last = first;
            while (last + 1 < vecs.size() && vecs[last+1].test == vecs[first].test)
            begin
                last++;
            end
            if (first != 0)
            begin
                gap = int'($urandom % 4);
                repeat (gap) next_cycle();
            end
            run_test(first, last);
            first = last + 1;
        end
        $display("Done: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && tests_run > 0)
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Generous bound of twenty cycles per record plus reset and the sweep
    initial
    begin
        longint limit;
        wait (loaded);
        limit = (longint'(vecs.size()) * 20 + RESET_LEN + SWEEP_LEN) * CLK_PERIOD;
        #(limit);
        $display("Timeout: the run did not finish within %0d ns", limit);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/eop_vectors.txt ====
# test cyc | r0v r0md r0len | r1v r1md r1len | s0v s0md s0data | s1v s1md s1fmt s1cl | ci0 ci1
# | e0v e0md e0data e0eop | e1v e1md e1fmt e1cl e1eop | co0 co1   (all hex, missing cycles idle)
1 00 0 00 0 0 00 0 0 00 0000 0 00 0 0 1 0 0 00 0000 0 0 00 0 0 0 0 0
1 01 0 00 0 0 00 0 0 00 0000 0 00 0 0 1 1 0 00 0000 0 0 00 0 0 0 0 0
1 02 0 00 0 0 00 0 0 00 0000 0 00 0 0 1 0 0 00 0000 0 0 00 0 0 0 0 0
1 10 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 1 1
1 11 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 1 0 00 0000 0 0 00 0 0 0 1 0
1 12 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 1 1
1 13 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
2 00 1 01 0 0 00 0 0 00 0000 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
2 01 1 02 0 0 00 0 0 00 0000 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
2 02 0 00 0 0 00 0 1 01 abcd 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
2 03 0 00 0 0 00 0 1 02 1234 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
2 05 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 0 1 01 abcd 1 0 00 0 0 0 0 0
2 06 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 0 1 02 1234 1 0 00 0 0 0 0 0
3 00 1 03 2 0 00 0 0 00 0000 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
3 01 1 04 1 0 00 0 0 00 0000 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
3 02 0 00 0 0 00 0 1 03 3000 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
3 03 0 00 0 0 00 0 1 03 3001 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
3 04 0 00 0 0 00 0 1 04 4000 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
3 05 0 00 0 0 00 0 1 03 3002 0 00 0 0 0 0 1 03 3000 0 0 00 0 0 0 0 0
3 06 0 00 0 0 00 0 1 04 4001 0 00 0 0 0 0 1 03 3001 0 0 00 0 0 0 0 0
3 07 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 0 1 04 4000 0 0 00 0 0 0 0 0
3 08 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 0 1 03 3002 1 0 00 0 0 0 0 0
3 09 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 0 1 04 4001 1 0 00 0 0 0 0 0
4 00 0 00 0 1 05 3 0 00 0000 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
4 01 0 00 0 0 00 0 0 00 0000 1 05 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
4 02 0 00 0 0 00 0 0 00 0000 1 05 0 1 0 0 0 00 0000 0 0 00 0 0 0 0 0
4 03 0 00 0 0 00 0 0 00 0000 1 05 0 2 0 0 0 00 0000 0 0 00 0 0 0 0 0
4 04 0 00 0 0 00 0 0 00 0000 1 05 0 3 0 0 0 00 0000 0 0 00 0 0 0 0 0
4 07 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 0 0 00 0000 0 1 05 1 3 1 0 0
5 00 0 00 0 1 06 2 0 00 0000 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
5 02 0 00 0 0 00 0 0 00 0000 1 06 1 2 0 0 0 00 0000 0 0 00 0 0 0 0 0
5 03 0 00 0 0 00 0 1 87 beef 0 00 0 0 0 0 0 00 0000 0 0 00 0 0 0 0 0
5 05 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 0 0 00 0000 0 1 06 1 2 1 0 0
5 06 0 00 0 0 00 0 0 00 0000 0 00 0 0 0 0 1 87 beef 0 0 00 0 0 0 0 0

// ==== sim.f ====
+incdir+logic
logic/eop_pkg.sv
logic/eop_ram.sv
logic/eop_flit_tracker.sv
logic/eop_detect_shim.sv
tests/eop_detect_props.sv
tests/eop_detect_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the EOP shim testbench with Verilator, run it, and judge the log.
set -e

cd "$(dirname "$0")"

rm -rf build
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
    --top-module eop_detect_tb \
    -Mdir build -o eop_sim \
    -f sim.f

./build/eop_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
    exit 0
fi
exit 1
